// File: rtl/br_pkg.sv
package br_pkg;

  localparam int xlen  = 32;  // data and address width
  localparam int tag_w = 6;   // 64 physical registers
  localparam int rob_w = 5;   // reorder buffer index

  // branch conditions, funct3 field of the B-type encoding
  localparam logic [2:0] beq  = 3'b000;
  localparam logic [2:0] bne  = 3'b001;
  localparam logic [2:0] blt  = 3'b100;
  localparam logic [2:0] bge  = 3'b101;
  localparam logic [2:0] bltu = 3'b110;
  localparam logic [2:0] bgeu = 3'b111;

  // micro-op class as sent by rename
  typedef enum logic [1:0] {
    kind_branch = 2'd0,
    kind_jal    = 2'd1,
    kind_jalr   = 2'd2
  } br_kind_t;

endpackage

// File: rtl/br_rs_queue.sv
`timescale 1ns/1ps

module br_rs_queue #(
  parameter int depth  = 8,
  parameter int num_wb = 3
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush,
  input  logic                     disp_req,
  input  br_pkg::br_kind_t         disp_kind,
  input  logic [2:0]               disp_funct3,
  input  logic [br_pkg::xlen-1:0]  disp_pc,
  input  logic [br_pkg::xlen-1:0]  disp_imm,
  input  logic [br_pkg::tag_w-1:0] disp_src1,
  input  logic [br_pkg::tag_w-1:0] disp_src2,
  input  logic                     disp_rdy1,
  input  logic                     disp_rdy2,
  input  logic                     disp_pred_taken,
  input  logic [br_pkg::rob_w-1:0] disp_rob_id,
  output logic                     disp_ack,
  input  logic [num_wb-1:0]        wb_valid,
  input  logic [br_pkg::tag_w-1:0] wb_tag [num_wb],
  output logic                     iss_valid,
  output br_pkg::br_kind_t         iss_kind,
  output logic [2:0]               iss_funct3,
  output logic [br_pkg::xlen-1:0]  iss_pc,
  output logic [br_pkg::xlen-1:0]  iss_imm,
  output logic [br_pkg::tag_w-1:0] iss_src1,
  output logic [br_pkg::tag_w-1:0] iss_src2,
  output logic                     iss_pred_taken,
  output logic [br_pkg::rob_w-1:0] iss_rob_id
);
  import br_pkg::*;

  localparam int ptr_w = $clog2(depth);

  // entry payload
  br_kind_t         kind_q   [depth];
  logic [2:0]       funct3_q [depth];
  logic [xlen-1:0]  pc_q     [depth];
  logic [xlen-1:0]  imm_q    [depth];
  logic [tag_w-1:0] src1_q   [depth];
  logic [tag_w-1:0] src2_q   [depth];
  logic [rob_w-1:0] rob_q    [depth];
  logic [depth-1:0] pred_q;

  logic [depth-1:0] rdy1_q;  // per-entry operand ready
  logic [depth-1:0] rdy2_q;
  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] tail;
  logic [ptr_w:0]   count;

  logic full;
  logic accept;
  logic issue;
  logic byp1;
  logic byp2;
  logic new_rdy1;
  logic new_rdy2;

  assign full   = (count == (ptr_w+1)'(depth));
  assign accept = disp_req && !disp_ack && !full && !flush;
  // only the head may go, younger ready entries wait behind it
  assign issue  = (count != '0) && rdy1_q[head] && rdy2_q[head] && !flush;

  // result bus carrying a source tag in the dispatch cycle
  always_comb begin
    byp1 = 1'b0;
    byp2 = 1'b0;
    for (int w = 0; w < num_wb; w++) begin
      if (wb_valid[w] && (wb_tag[w] == disp_src1)) byp1 = 1'b1;
      if (wb_valid[w] && (wb_tag[w] == disp_src2)) byp2 = 1'b1;
    end
  end

  // jal reads no register, jalr has no rs2
  assign new_rdy1 = disp_rdy1 || byp1 || (disp_kind == kind_jal);
  assign new_rdy2 = disp_rdy2 || byp2 || (disp_kind != kind_branch);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      disp_ack  <= 1'b0;
      iss_valid <= 1'b0;
      rdy1_q    <= '0;
      rdy2_q    <= '0;
    end else begin
      // tag wakeup over every slot
      for (int i = 0; i < depth; i++) begin
        for (int w = 0; w < num_wb; w++) begin
          if (wb_valid[w] && (wb_tag[w] == src1_q[i])) rdy1_q[i] <= 1'b1;
          if (wb_valid[w] && (wb_tag[w] == src2_q[i])) rdy2_q[i] <= 1'b1;
        end
      end
      if (accept) begin
        rdy1_q[tail] <= new_rdy1;  // overrides wakeup of the stale slot
        rdy2_q[tail] <= new_rdy2;
      end

      // four-phase ack, low again once req drops
      if (accept) begin
        disp_ack <= 1'b1;
      end else if (!disp_req) begin
        disp_ack <= 1'b0;
      end

      iss_valid <= issue;

      if (flush) begin
        head  <= '0;
        tail  <= '0;
        count <= '0;
      end else begin
        if (issue) head <= head + 1'b1;
        if (accept) tail <= tail + 1'b1;
        count <= count + {{ptr_w{1'b0}}, accept} - {{ptr_w{1'b0}}, issue};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      kind_q[tail]   <= disp_kind;
      funct3_q[tail] <= disp_funct3;
      pc_q[tail]     <= disp_pc;
      imm_q[tail]    <= disp_imm;
      src1_q[tail]   <= disp_src1;
      src2_q[tail]   <= disp_src2;
      pred_q[tail]   <= disp_pred_taken;
      rob_q[tail]    <= disp_rob_id;
    end
    if (issue) begin
      iss_kind       <= kind_q[head];
      iss_funct3     <= funct3_q[head];
      iss_pc         <= pc_q[head];
      iss_imm        <= imm_q[head];
      iss_src1       <= src1_q[head];
      iss_src2       <= src2_q[head];
      iss_pred_taken <= pred_q[head];
      iss_rob_id     <= rob_q[head];
    end
  end

endmodule

// File: rtl/preg_file.sv
`timescale 1ns/1ps

module preg_file #(
  parameter int num_wb = 3
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [num_wb-1:0]        wb_valid,
  input  logic [br_pkg::tag_w-1:0] wb_tag  [num_wb],
  input  logic [br_pkg::xlen-1:0]  wb_data [num_wb],
  input  logic [br_pkg::tag_w-1:0] rd_tag1,
  input  logic [br_pkg::tag_w-1:0] rd_tag2,
  output logic [br_pkg::xlen-1:0]  rd_data1,
  output logic [br_pkg::xlen-1:0]  rd_data2
);
  import br_pkg::*;

  localparam int num_pregs = 2 ** tag_w;

  logic [xlen-1:0] regs [num_pregs];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_pregs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // loop order lets the higher bus index win a collision
      for (int w = 0; w < num_wb; w++) begin
        if (wb_valid[w] && (wb_tag[w] != '0)) begin  // p0 is x0, never written
          regs[wb_tag[w]] <= wb_data[w];
        end
      end
    end
  end

  // read ports for the issuing entry
  assign rd_data1 = regs[rd_tag1];
  assign rd_data2 = regs[rd_tag2];

endmodule

// File: rtl/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     iss_valid,
  input  br_pkg::br_kind_t         iss_kind,
  input  logic [2:0]               iss_funct3,
  input  logic [br_pkg::xlen-1:0]  iss_pc,
  input  logic [br_pkg::xlen-1:0]  iss_imm,
  input  logic                     iss_pred_taken,
  input  logic [br_pkg::rob_w-1:0] iss_rob_id,
  input  logic [br_pkg::xlen-1:0]  op1,
  input  logic [br_pkg::xlen-1:0]  op2,
  output logic                     res_valid,
  output logic                     res_taken,
  output logic [br_pkg::xlen-1:0]  res_target,
  output logic [br_pkg::xlen-1:0]  res_link,
  output logic                     res_mispredict,
  output logic [br_pkg::rob_w-1:0] res_rob_id
);
  import br_pkg::*;

  logic            cond;
  logic            taken;
  logic [xlen-1:0] target;
  logic [xlen-1:0] jalr_sum;

  always_comb begin
    case (iss_funct3)
      beq:     cond = (op1 == op2);
      bne:     cond = (op1 != op2);
      blt:     cond = ($signed(op1) < $signed(op2));
      bge:     cond = ($signed(op1) >= $signed(op2));
      bltu:    cond = (op1 < op2);
      bgeu:    cond = (op1 >= op2);
      default: cond = 1'b0;  // 010 and 011 are not branches
    endcase
  end

  assign jalr_sum = op1 + iss_imm;

  // jumps always taken, pc-relative unless jalr
  always_comb begin
    taken  = 1'b1;
    target = iss_pc + iss_imm;
    case (iss_kind)
      kind_branch: taken = cond;
      kind_jalr:   target = {jalr_sum[xlen-1:1], 1'b0};
      default:     taken = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid      <= 1'b0;
      res_mispredict <= 1'b0;
    end else begin
      res_valid      <= iss_valid;
      res_mispredict <= iss_valid && (taken != iss_pred_taken);
    end
  end

  always_ff @(posedge clk) begin
    if (iss_valid) begin
      res_taken  <= taken;
      res_target <= target;
      res_link   <= iss_pc + xlen'(4);  // return address
      res_rob_id <= iss_rob_id;
    end
  end

endmodule

// File: rtl/br_subsystem.sv
`timescale 1ns/1ps

module br_subsystem #(
  parameter int depth  = 8,
  parameter int num_wb = 3
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush,
  input  logic                     disp_req,
  input  br_pkg::br_kind_t         disp_kind,
  input  logic [2:0]               disp_funct3,
  input  logic [br_pkg::xlen-1:0]  disp_pc,
  input  logic [br_pkg::xlen-1:0]  disp_imm,
  input  logic [br_pkg::tag_w-1:0] disp_src1,
  input  logic [br_pkg::tag_w-1:0] disp_src2,
  input  logic                     disp_rdy1,
  input  logic                     disp_rdy2,
  input  logic                     disp_pred_taken,
  input  logic [br_pkg::rob_w-1:0] disp_rob_id,
  output logic                     disp_ack,
  input  logic [num_wb-1:0]        wb_valid,
  input  logic [br_pkg::tag_w-1:0] wb_tag  [num_wb],
  input  logic [br_pkg::xlen-1:0]  wb_data [num_wb],
  output logic                     res_valid,
  output logic                     res_taken,
  output logic [br_pkg::xlen-1:0]  res_target,
  output logic [br_pkg::xlen-1:0]  res_link,
  output logic                     res_mispredict,
  output logic [br_pkg::rob_w-1:0] res_rob_id
);
  import br_pkg::*;

  logic             iss_valid;
  br_kind_t         iss_kind;
  logic [2:0]       iss_funct3;
  logic [xlen-1:0]  iss_pc;
  logic [xlen-1:0]  iss_imm;
  logic [tag_w-1:0] iss_src1;
  logic [tag_w-1:0] iss_src2;
  logic             iss_pred_taken;
  logic [rob_w-1:0] iss_rob_id;
  logic [xlen-1:0]  op1;
  logic [xlen-1:0]  op2;
  logic             q_flush;

  // exception/mret or a wrong-path redirect both drop the queue
  assign q_flush = flush || res_mispredict;

  br_rs_queue #(
    .depth  (depth),
    .num_wb (num_wb)
  ) u_rs_queue (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush           (q_flush),
    .disp_req        (disp_req),
    .disp_kind       (disp_kind),
    .disp_funct3     (disp_funct3),
    .disp_pc         (disp_pc),
    .disp_imm        (disp_imm),
    .disp_src1       (disp_src1),
    .disp_src2       (disp_src2),
    .disp_rdy1       (disp_rdy1),
    .disp_rdy2       (disp_rdy2),
    .disp_pred_taken (disp_pred_taken),
    .disp_rob_id     (disp_rob_id),
    .disp_ack        (disp_ack),
    .wb_valid        (wb_valid),
    .wb_tag          (wb_tag),
    .iss_valid       (iss_valid),
    .iss_kind        (iss_kind),
    .iss_funct3      (iss_funct3),
    .iss_pc          (iss_pc),
    .iss_imm         (iss_imm),
    .iss_src1        (iss_src1),
    .iss_src2        (iss_src2),
    .iss_pred_taken  (iss_pred_taken),
    .iss_rob_id      (iss_rob_id)
  );

  // operands read in the issue cycle
  preg_file #(
    .num_wb (num_wb)
  ) u_preg_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_valid (wb_valid),
    .wb_tag   (wb_tag),
    .wb_data  (wb_data),
    .rd_tag1  (iss_src1),
    .rd_tag2  (iss_src2),
    .rd_data1 (op1),
    .rd_data2 (op2)
  );

  branch_resolve u_resolve (
    .clk            (clk),
    .rst_n          (rst_n),
    .iss_valid      (iss_valid),
    .iss_kind       (iss_kind),
    .iss_funct3     (iss_funct3),
    .iss_pc         (iss_pc),
    .iss_imm        (iss_imm),
    .iss_pred_taken (iss_pred_taken),
    .iss_rob_id     (iss_rob_id),
    .op1            (op1),
    .op2            (op2),
    .res_valid      (res_valid),
    .res_taken      (res_taken),
    .res_target     (res_target),
    .res_link       (res_link),
    .res_mispredict (res_mispredict),
    .res_rob_id     (res_rob_id)
  );

endmodule

// File: tests/tb_br_subsystem.sv
`timescale 1ns/1ps

module tb_br_subsystem;
  import br_pkg::*;

  localparam int depth  = 8;
  localparam int num_wb = 3;
  localparam int limit  = 50;  // cycles before a wait gives up
  localparam int rows   = 12;

  typedef struct packed {
    br_kind_t         kind;
    logic [2:0]       f3;
    logic [xlen-1:0]  pc;
    logic [xlen-1:0]  imm;
    logic [tag_w-1:0] t1;
    logic [xlen-1:0]  v1;
    logic             r1;
    logic [tag_w-1:0] t2;
    logic [xlen-1:0]  v2;
    logic             r2;
    logic             pred;
    logic             rnd;  // random operand values
  } row_t;

  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] target;
    logic [xlen-1:0] link;
    logic            misp;
  } exp_t;

  typedef struct packed {
    logic [rob_w-1:0] rob;
    logic             taken;
    logic [xlen-1:0]  target;
    logic [xlen-1:0]  link;
    logic             misp;
  } res_t;

  logic             clk;
  logic             rst_n;
  logic             flush;
  logic             disp_req;
  br_kind_t         disp_kind;
  logic [2:0]       disp_funct3;
  logic [xlen-1:0]  disp_pc;
  logic [xlen-1:0]  disp_imm;
  logic [tag_w-1:0] disp_src1;
  logic [tag_w-1:0] disp_src2;
  logic             disp_rdy1;
  logic             disp_rdy2;
  logic             disp_pred_taken;
  logic [rob_w-1:0] disp_rob_id;
  logic             disp_ack;
  logic [num_wb-1:0] wb_valid;
  logic [tag_w-1:0] wb_tag  [num_wb];
  logic [xlen-1:0]  wb_data [num_wb];
  logic             res_valid;
  logic             res_taken;
  logic [xlen-1:0]  res_target;
  logic [xlen-1:0]  res_link;
  logic             res_mispredict;
  logic [rob_w-1:0] res_rob_id;

  row_t tbl [rows];
  res_t res_q [$];
  int   mism_cnt = 0;
  int   fail_cnt = 0;

  br_subsystem #(
    .depth  (depth),
    .num_wb (num_wb)
  ) u_br_subsystem (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // collect every resolved branch
  always @(negedge clk) begin
    if (rst_n && res_valid) begin
      res_q.push_back('{res_rob_id, res_taken, res_target, res_link, res_mispredict});
    end
  end

  function automatic row_t make_row(br_kind_t kind, logic [2:0] f3, logic [xlen-1:0] pc,
                                    logic [xlen-1:0] imm, logic [tag_w-1:0] t1,
                                    logic [xlen-1:0] v1, logic r1, logic [tag_w-1:0] t2,
                                    logic [xlen-1:0] v2, logic r2, logic pred, logic rnd);
    return '{kind, f3, pc, imm, t1, v1, r1, t2, v2, r2, pred, rnd};
  endfunction

  // expected outcome straight from the RV32 branch rules
  function automatic exp_t model(br_kind_t kind, logic [2:0] f3, logic [xlen-1:0] pc,
                                 logic [xlen-1:0] imm, logic [xlen-1:0] a,
                                 logic [xlen-1:0] b, logic pred);
    exp_t e;
    e.taken  = 1'b1;
    e.target = pc + imm;
    e.link   = pc + 32'd4;
    if (kind == kind_branch) begin
      case (f3)
        beq:     e.taken = (a == b);
        bne:     e.taken = (a != b);
        blt:     e.taken = ($signed(a) < $signed(b));
        bge:     e.taken = ($signed(a) >= $signed(b));
        bltu:    e.taken = (a < b);
        bgeu:    e.taken = (a >= b);
        default: e.taken = 1'b0;
      endcase
    end else if (kind == kind_jalr) begin
      e.target = (a + imm) & ~32'd1;
    end
    e.misp = (e.taken != pred);
    return e;
  endfunction

  task automatic check_val(string name, logic [xlen-1:0] got, logic [xlen-1:0] exp);
    if (got !== exp) begin
      mism_cnt++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  // one cycle on buses 0 and 1, tag 0 left alone
  task automatic write_reg(logic [tag_w-1:0] t1, logic [xlen-1:0] v1,
                           logic [tag_w-1:0] t2, logic [xlen-1:0] v2);
    @(negedge clk);
    wb_valid   = {1'b0, t2 != '0, t1 != '0};
    wb_tag[0]  = t1;
    wb_data[0] = v1;
    wb_tag[1]  = t2;
    wb_data[1] = v2;
    @(negedge clk);
    wb_valid = '0;
  endtask

  task automatic drive_req(br_kind_t kind, logic [2:0] f3, logic [xlen-1:0] pc,
                           logic [xlen-1:0] imm, logic [tag_w-1:0] t1, logic r1,
                           logic [tag_w-1:0] t2, logic r2, logic pred,
                           logic [rob_w-1:0] rob);
    int n;
    n = 0;
    @(negedge clk);
    while (disp_ack && n < limit) begin  // previous ack must be gone
      @(negedge clk);
      n++;
    end
    if (disp_ack) begin
      fail_cnt++;
      $display("disp_ack stayed high with no request pending");
    end
    disp_kind       = kind;
    disp_funct3     = f3;
    disp_pc         = pc;
    disp_imm        = imm;
    disp_src1       = t1;
    disp_rdy1       = r1;
    disp_src2       = t2;
    disp_rdy2       = r2;
    disp_pred_taken = pred;
    disp_rob_id     = rob;
    disp_req        = 1'b1;
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!disp_ack && n < limit);
    if (!disp_ack) begin
      fail_cnt++;
      $display("timeout waiting for disp_ack, rob %h", disp_rob_id);
    end
    disp_req = 1'b0;
  endtask

  task automatic dispatch(br_kind_t kind, logic [2:0] f3, logic [xlen-1:0] pc,
                          logic [xlen-1:0] imm, logic [tag_w-1:0] t1, logic r1,
                          logic [tag_w-1:0] t2, logic r2, logic pred,
                          logic [rob_w-1:0] rob);
    drive_req(kind, f3, pc, imm, t1, r1, t2, r2, pred, rob);
    wait_ack();
  endtask

  task automatic check_result(logic [rob_w-1:0] rob, exp_t e);
    res_t r;
    int   n;
    n = 0;
    while (res_q.size() == 0 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (res_q.size() == 0) begin
      fail_cnt++;
      $display("no branch result arrived for rob %h", rob);
    end else begin
      r = res_q.pop_front();
      check_val("res_rob_id", r.rob, rob);
      check_val("res_taken", r.taken, e.taken);
      check_val("res_target", r.target, e.target);
      check_val("res_link", r.link, e.link);
      check_val("res_mispredict", r.misp, e.misp);
    end
  endtask

  task automatic expect_no_result(int cycles);
    repeat (cycles) @(posedge clk);
    if (res_q.size() != 0) begin
      fail_cnt++;
      $display("%0d unexpected results, first from rob %h", res_q.size(), res_q[0].rob);
      res_q.delete();
    end
  endtask

  // ready operands on an empty queue, result two edges after accept
  task automatic run_row(int i);
    row_t r;
    r = tbl[i];
    if (r.rnd) begin
      r.v1 = $urandom;
      r.v2 = $urandom;
    end
    write_reg(r.t1, r.v1, r.t2, r.v2);
    dispatch(r.kind, r.f3, r.pc, r.imm, r.t1, r.r1, r.t2, r.r2, r.pred, rob_w'(i));
    @(negedge clk);
    check_val("res_valid", res_valid, 1'b0);
    @(negedge clk);
    check_val("res_valid", res_valid, 1'b1);
    check_result(rob_w'(i), model(r.kind, r.f3, r.pc, r.imm, r.v1, r.v2, r.pred));
  endtask

  task automatic hold_behind_head();
    write_reg(6'd11, 32'h55, '0, '0);
    dispatch(kind_branch, beq, 32'h4000, 32'h20, 6'd10, 1'b0, 6'd11, 1'b1, 1'b1, 5'd20);
    dispatch(kind_jal, beq, 32'h4100, 32'h40, '0, 1'b1, '0, 1'b1, 1'b1, 5'd21);
    expect_no_result(8);
    write_reg(6'd10, 32'h55, '0, '0);  // wake the older entry
    check_result(5'd20, model(kind_branch, beq, 32'h4000, 32'h20, 32'h55, 32'h55, 1'b1));
    check_result(5'd21, model(kind_jal, beq, 32'h4100, 32'h40, '0, '0, 1'b1));
  endtask

  task automatic fill_queue();
    bit acked;
    acked = 1'b0;
    for (int i = 0; i < depth; i++) begin
      dispatch(kind_branch, beq, 32'h5000 + 4 * i, 32'h8, 6'(20 + i), 1'b0, '0, 1'b1,
               1'b1, rob_w'(i));
    end
    drive_req(kind_jal, beq, 32'h5100, 32'h80, '0, 1'b1, '0, 1'b1, 1'b1, 5'd8);
    repeat (10) begin
      @(negedge clk);
      if (disp_ack) acked = 1'b1;
    end
    if (acked) begin
      fail_cnt++;
      $display("dispatch accepted while the queue was full");
    end
    write_reg(6'd20, 32'h0, '0, '0);
    wait_ack();
    for (int i = 1; i < depth; i++) begin
      write_reg(6'(20 + i), 32'h0, '0, '0);
    end
    for (int i = 0; i < depth; i++) begin
      check_result(rob_w'(i), model(kind_branch, beq, 32'h5000 + 4 * i, 32'h8, '0, '0, 1'b1));
    end
    check_result(5'd8, model(kind_jal, beq, 32'h5100, 32'h80, '0, '0, 1'b1));
  endtask

  task automatic drop_after_mispredict();
    dispatch(kind_branch, bne, 32'h6000, 32'h100, 6'd30, 1'b0, '0, 1'b1, 1'b1, 5'd24);
    dispatch(kind_branch, beq, 32'h6004, 32'h20, 6'd31, 1'b0, '0, 1'b1, 1'b1, 5'd25);
    dispatch(kind_jalr, beq, 32'h6008, 32'h0, 6'd31, 1'b0, '0, 1'b1, 1'b1, 5'd26);
    write_reg(6'd30, 32'h0, '0, '0);
    check_result(5'd24, model(kind_branch, bne, 32'h6000, 32'h100, '0, '0, 1'b1));
    write_reg(6'd31, 32'h6100, '0, '0);  // would wake the younger ones
    expect_no_result(10);
  endtask

  task automatic drop_on_flush();
    dispatch(kind_branch, beq, 32'h7000, 32'h10, 6'd33, 1'b0, '0, 1'b1, 1'b1, 5'd27);
    dispatch(kind_jal, beq, 32'h7004, 32'h10, '0, 1'b1, '0, 1'b1, 1'b1, 5'd28);
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    write_reg(6'd33, 32'h0, '0, '0);
    expect_no_result(10);
    run_row(0);  // queue empty again, so plain latency
  endtask

  initial begin
    void'($urandom(32'h77a37aa2));
    rst_n           = 1'b0;
    flush           = 1'b0;
    disp_req        = 1'b0;
    disp_kind       = kind_branch;
    disp_funct3     = beq;
    disp_pc         = '0;
    disp_imm        = '0;
    disp_src1       = '0;
    disp_src2       = '0;
    disp_rdy1       = 1'b0;
    disp_rdy2       = 1'b0;
    disp_pred_taken = 1'b0;
    disp_rob_id     = '0;
    wb_valid        = '0;
    for (int w = 0; w < num_wb; w++) begin
      wb_tag[w]  = '0;
      wb_data[w] = '0;
    end

    // signed and unsigned boundaries, then jumps
    tbl[0]  = make_row(kind_branch, beq, 32'h1000, 32'h10, 6'd5, 32'h12345678, 1'b1,
                       6'd6, 32'h12345678, 1'b1, 1'b1, 1'b0);
    tbl[1]  = make_row(kind_branch, bne, 32'h1040, 32'h24, 6'd5, 32'h12345678, 1'b1,
                       6'd6, 32'h12345678, 1'b1, 1'b1, 1'b0);
    tbl[2]  = make_row(kind_branch, blt, 32'h1080, 32'hfffffff0, 6'd5, 32'h80000000, 1'b1,
                       6'd6, 32'h00000001, 1'b1, 1'b0, 1'b0);
    tbl[3]  = make_row(kind_branch, bltu, 32'h10c0, 32'h100, 6'd5, 32'h80000000, 1'b1,
                       6'd6, 32'h00000001, 1'b1, 1'b0, 1'b0);
    tbl[4]  = make_row(kind_branch, bge, 32'h1100, 32'h8, 6'd8, 32'h7fffffff, 1'b1,
                       6'd9, 32'h80000000, 1'b1, 1'b1, 1'b0);
    tbl[5]  = make_row(kind_branch, bgeu, 32'h1140, 32'h8, 6'd8, 32'h7fffffff, 1'b1,
                       6'd9, 32'h80000000, 1'b1, 1'b1, 1'b0);
    tbl[6]  = make_row(kind_branch, bge, 32'h1180, 32'hc, 6'd8, 32'hffffffff, 1'b1,
                       6'd9, 32'hffffffff, 1'b1, 1'b1, 1'b0);
    tbl[7]  = make_row(kind_branch, bltu, 32'h11c0, 32'h40, 6'd5, 32'h00000000, 1'b1,
                       6'd6, 32'hffffffff, 1'b1, 1'b1, 1'b0);
    tbl[8]  = make_row(kind_branch, beq, 32'h1200, 32'h14, 6'd5, 32'h0, 1'b1,
                       6'd6, 32'h0, 1'b1, 1'b0, 1'b1);
    tbl[9]  = make_row(kind_jal, beq, 32'h2000, 32'hfffff800, 6'd0, 32'h0, 1'b1,
                       6'd0, 32'h0, 1'b1, 1'b1, 1'b0);
    tbl[10] = make_row(kind_jalr, beq, 32'h3000, 32'h10, 6'd7, 32'h00003001, 1'b1,
                       6'd0, 32'h0, 1'b1, 1'b0, 1'b0);
    tbl[11] = make_row(kind_jalr, beq, 32'h3400, 32'hffffff03, 6'd7, 32'h0, 1'b1,
                       6'd0, 32'h0, 1'b1, 1'b1, 1'b1);

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // quiet after reset
    repeat (5) begin
      @(negedge clk);
      check_val("disp_ack", disp_ack, 1'b0);
      check_val("res_valid", res_valid, 1'b0);
      check_val("res_mispredict", res_mispredict, 1'b0);
    end

    for (int i = 0; i < rows; i++) begin
      run_row(i);
      repeat ($urandom_range(3)) @(negedge clk);  // idle gap
    end
    hold_behind_head();
    fill_queue();
    drop_after_mispredict();
    drop_on_flush();

    $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: br_subsystem.f
rtl/br_pkg.sv
rtl/br_rs_queue.sv
rtl/preg_file.sv
rtl/branch_resolve.sv
rtl/br_subsystem.sv
tests/tb_br_subsystem.sv

// File: Bender.yml
package:
  name: br_subsystem

sources:
  - rtl/br_pkg.sv
  - rtl/br_rs_queue.sv
  - rtl/preg_file.sv
  - rtl/branch_resolve.sv
  - rtl/br_subsystem.sv
  - target: test
    files:
      - tests/tb_br_subsystem.sv
